// File: source/tlk_rx_pkg.sv
// tlk2711 receive parser shared code words, widths, state type and header word view
package tlk_rx_pkg;

    ////////////////////////////////////////
    // stream widths
    ////////////////////////////////////////

    // serdes word, two bytes per clock
    localparam int WORD_W = 16;
    // line number carried over two header words
    localparam int LINE_W = 24;

    ////////////////////////////////////////
    // code words
    ////////////////////////////////////////

    // sync pair, k char low byte, data high byte
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;

    // start of frame pair, k char in both bytes
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;

    // upper half arrives first, then lower half
    localparam logic [31:0] FRAME_HEAD_FLAG = 32'heb90_e116;

    // all ones with both k flags means the link dropped
    localparam logic [WORD_W-1:0] LINK_LOSS_WORD = 16'hFFFF;

    ////////////////////////////////////////
    // receive fsm
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        idle_s        = 4'd0,
        sync_s        = 4'd1,
        frame_head_s  = 4'd2,
        data_type_s   = 4'd3,
        line_infor_s  = 4'd4,
        data_length_s = 4'd5,
        recv_data_s   = 4'd6,
        check_data_s  = 4'd7,
        frame_end1_s  = 4'd8,
        frame_end2_s  = 4'd9
    } rx_state_t;

    // first header word, fields from the msb end
    typedef struct packed {
        logic [1:0] file_end;
        logic [1:0] channel_id;
        logic [3:0] data_type;
        logic [7:0] line_hi;
    } hdr_fields_t;

    // same word seen raw by the checksum adder
    typedef union packed {
        logic [WORD_W-1:0] raw;
        hdr_fields_t       f;
    } hdr_word_u;

endpackage

// File: source/frame_info_if.sv
// decoded frame fields and done strobe from the parser to the report block
`timescale 1ns/1ps

interface frame_info_if;

    // one cycle, frame finished
    logic                              frame_done;
    // level, held until next compare
    logic                              checksum_err;

    // header fields, stable from data_length onward
    logic [3:0]                        data_type;
    logic [1:0]                        channel_id;
    logic                              file_end;
    logic [tlk_rx_pkg::LINE_W-1:0]     line_number;
    // payload length in bytes
    logic [tlk_rx_pkg::WORD_W-1:0]     data_length;

    modport src (output frame_done, checksum_err, data_type, channel_id,
                 file_end, line_number, data_length);

    modport dst (input frame_done, checksum_err, data_type, channel_id,
                 file_end, line_number, data_length);

endinterface

// File: source/tlk_frame_parser.sv
// receive fsm, locks on sync and head flag, decodes header, counts payload and checks sum
`timescale 1ns/1ps

module tlk_frame_parser (
    input  logic                          i_2711_rx_clk,
    input  logic                          i_rst_n,
    input  logic                          i_2711_rkmsb,
    input  logic                          i_2711_rklsb,
    input  logic [tlk_rx_pkg::WORD_W-1:0] i_2711_rxd,
    output logic                          o_in_frame,
    output tlk_rx_pkg::rx_state_t         o_state,
    frame_info_if.src                     info
);

    tlk_rx_pkg::rx_state_t          cs;
    tlk_rx_pkg::rx_state_t          ns;
    // current word through the header view
    tlk_rx_pkg::hdr_word_u          word_u;
    // one word delay for the 32 bit head flag
    logic [tlk_rx_pkg::WORD_W-1:0]  prev_word;
    logic [tlk_rx_pkg::WORD_W-2:0]  word_cnt;
    logic [tlk_rx_pkg::WORD_W-1:0]  checksum;
    logic                           payload_last;

    assign word_u.raw = i_2711_rxd;

    // length is in bytes, two bytes per word
    assign payload_last = (word_cnt == info.data_length[tlk_rx_pkg::WORD_W-1:1] - 15'd1);

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cs <= tlk_rx_pkg::idle_s;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            tlk_rx_pkg::idle_s: begin
                // k flag only on the low byte
                if (!i_2711_rkmsb && i_2711_rklsb &&
                    i_2711_rxd == {tlk_rx_pkg::D5_6, tlk_rx_pkg::K28_5}) begin
                    ns = tlk_rx_pkg::sync_s;
                end
            end
            tlk_rx_pkg::sync_s: begin
                if (i_2711_rkmsb && i_2711_rklsb &&
                    i_2711_rxd == {tlk_rx_pkg::K28_2, tlk_rx_pkg::K27_7}) begin
                    ns = tlk_rx_pkg::frame_head_s;
                end
            end
            tlk_rx_pkg::frame_head_s: begin
                // wait here until both halves line up
                if ({prev_word, i_2711_rxd} == tlk_rx_pkg::FRAME_HEAD_FLAG) begin
                    ns = tlk_rx_pkg::data_type_s;
                end
            end
            tlk_rx_pkg::data_type_s:   ns = tlk_rx_pkg::line_infor_s;
            tlk_rx_pkg::line_infor_s:  ns = tlk_rx_pkg::data_length_s;
            tlk_rx_pkg::data_length_s: ns = tlk_rx_pkg::recv_data_s;
            tlk_rx_pkg::recv_data_s: begin
                if (payload_last) begin
                    ns = tlk_rx_pkg::check_data_s;
                end
            end
            tlk_rx_pkg::check_data_s:  ns = tlk_rx_pkg::frame_end1_s;
            tlk_rx_pkg::frame_end1_s:  ns = tlk_rx_pkg::frame_end2_s;
            default:                   ns = tlk_rx_pkg::idle_s;
        endcase
    end

    // header through checksum word
    assign o_in_frame = (cs >= tlk_rx_pkg::data_type_s) && (cs <= tlk_rx_pkg::check_data_s);
    assign o_state    = cs;

    always_ff @(posedge i_2711_rx_clk) begin
        prev_word <= i_2711_rxd;
    end

    ////////////////////////////////////////
    // header capture
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        if (cs == tlk_rx_pkg::data_type_s) begin
            info.file_end                <= word_u.f.file_end[0];
            info.channel_id              <= word_u.f.channel_id;
            info.data_type               <= word_u.f.data_type;
            info.line_number[23:16]      <= word_u.f.line_hi;
        end
        if (cs == tlk_rx_pkg::line_infor_s) begin
            info.line_number[15:0] <= i_2711_rxd;
        end
        if (cs == tlk_rx_pkg::data_length_s) begin
            info.data_length <= i_2711_rxd;
        end
    end

    ////////////////////////////////////////
    // payload count and checksum
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            word_cnt          <= '0;
            checksum          <= '0;
            info.checksum_err <= 1'b0;
            info.frame_done   <= 1'b0;
        end else begin
            if (cs == tlk_rx_pkg::recv_data_s) begin
                word_cnt <= word_cnt + 15'd1;
            end else begin
                word_cnt <= '0;
            end

            case (cs)
                tlk_rx_pkg::idle_s, tlk_rx_pkg::sync_s, tlk_rx_pkg::frame_head_s: begin
                    checksum          <= '0;
                    info.checksum_err <= 1'b0;
                end
                tlk_rx_pkg::data_type_s, tlk_rx_pkg::line_infor_s,
                tlk_rx_pkg::data_length_s, tlk_rx_pkg::recv_data_s: begin
                    // wraps at 16 bits
                    checksum <= checksum + word_u.raw;
                end
                tlk_rx_pkg::check_data_s: begin
                    info.checksum_err <= (checksum != i_2711_rxd);
                end
                default: begin
                    checksum <= checksum;
                end
            endcase

            // lands while frame_end2 is current
            info.frame_done <= (cs == tlk_rx_pkg::frame_end1_s);
        end
    end

endmodule

// File: source/tlk_loss_monitor.sv
// link loss and sync loss detection, one pulse per fault then a holdoff window
`timescale 1ns/1ps

module tlk_loss_monitor #(
    parameter int LOSS_HOLDOFF = 10_000_000
) (
    input  logic                          i_2711_rx_clk,
    input  logic                          i_rst_n,
    input  logic                          i_2711_rkmsb,
    input  logic                          i_2711_rklsb,
    input  logic [tlk_rx_pkg::WORD_W-1:0] i_2711_rxd,
    input  logic                          i_in_frame,
    input  logic                          i_link_loss_det_ena,
    input  logic                          i_sync_loss_det_ena,
    output logic                          o_link_loss,
    output logic                          o_sync_loss
);

    // channel 0 is link loss, channel 1 is sync loss
    logic [1:0]  ena;
    logic [1:0]  det;
    logic [1:0]  pulse;
    logic [1:0]  hold;
    logic [23:0] timer [2];

    assign ena = {i_sync_loss_det_ena, i_link_loss_det_ena};

    // k coded all ones word
    assign det[0] = i_2711_rkmsb && i_2711_rklsb && (i_2711_rxd == tlk_rx_pkg::LINK_LOSS_WORD);
    // any k char between header and checksum
    assign det[1] = (i_2711_rkmsb || i_2711_rklsb) && i_in_frame;

    ////////////////////////////////////////
    // per channel pulse and holdoff
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pulse    <= '0;
            hold     <= '0;
            timer[0] <= '0;
            timer[1] <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (!ena[ch]) begin
                    // disabled channel stays fully idle
                    pulse[ch] <= 1'b0;
                    hold[ch]  <= 1'b0;
                    timer[ch] <= '0;
                end else if (det[ch] && !hold[ch]) begin
                    // fault seen, start holdoff on the same edge
                    pulse[ch] <= 1'b1;
                    hold[ch]  <= 1'b1;
                    timer[ch] <= '0;
                end else begin
                    pulse[ch] <= 1'b0;
                    if (hold[ch]) begin
                        if (timer[ch] == 24'(LOSS_HOLDOFF - 1)) begin
                            hold[ch]  <= 1'b0;
                            timer[ch] <= '0;
                        end else begin
                            timer[ch] <= timer[ch] + 24'd1;
                        end
                    end
                end
            end
        end
    end

    assign o_link_loss = pulse[0];
    assign o_sync_loss = pulse[1];

endmodule

// File: source/tlk_rx_report.sv
// registered frame report, frame counter and merged loss interrupt
`timescale 1ns/1ps

module tlk_rx_report (
    input  logic                          i_2711_rx_clk,
    input  logic                          i_rst_n,
    input  logic                          i_link_loss,
    input  logic                          i_sync_loss,
    frame_info_if.dst                     info,
    output logic                          o_frame_valid,
    output logic [tlk_rx_pkg::WORD_W-1:0] o_frame_length,
    output logic [tlk_rx_pkg::LINE_W-1:0] o_frame_num,
    output logic [3:0]                    o_data_type,
    output logic [1:0]                    o_channel_id,
    output logic                          o_file_end,
    output logic                          o_checksum_err,
    output logic [15:0]                   o_frame_count,
    output logic                          o_loss_irq
);

    ////////////////////////////////////////
    // strobes and counters
    ////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_frame_valid  <= 1'b0;
            o_checksum_err <= 1'b0;
            o_frame_count  <= '0;
            o_loss_irq     <= 1'b0;
        end else begin
            o_frame_valid <= info.frame_done;
            if (info.frame_done) begin
                o_checksum_err <= info.checksum_err;
                // wraps after 65535 frames
                o_frame_count  <= o_frame_count + 16'd1;
            end
            // either fault raises one interrupt
            o_loss_irq <= i_link_loss || i_sync_loss;
        end
    end

    // frame fields follow the done strobe
    always_ff @(posedge i_2711_rx_clk) begin
        if (info.frame_done) begin
            o_frame_length <= info.data_length;
            o_frame_num    <= info.line_number;
            o_data_type    <= info.data_type;
            o_channel_id   <= info.channel_id;
            o_file_end     <= info.file_end;
        end
    end

endmodule

// File: source/tlk2711_rx_top.sv
// tlk2711 receive top, parser, loss monitor and report on plain ports
`timescale 1ns/1ps

module tlk2711_rx_top #(
    parameter int LOSS_HOLDOFF = 10_000_000
) (
    input  logic                          i_2711_rx_clk,
    input  logic                          i_rst_n,
    input  logic                          i_2711_rkmsb,
    input  logic                          i_2711_rklsb,
    input  logic [tlk_rx_pkg::WORD_W-1:0] i_2711_rxd,
    input  logic                          i_link_loss_det_ena,
    input  logic                          i_sync_loss_det_ena,
    output logic                          o_frame_valid,
    output logic [tlk_rx_pkg::WORD_W-1:0] o_frame_length,
    output logic [tlk_rx_pkg::LINE_W-1:0] o_frame_num,
    output logic [3:0]                    o_data_type,
    output logic [1:0]                    o_channel_id,
    output logic                          o_file_end,
    output logic                          o_checksum_err,
    output logic [15:0]                   o_frame_count,
    output logic                          o_loss_irq,
    output logic                          o_link_loss,
    output logic                          o_sync_loss,
    output logic [3:0]                    o_rx_state
);

    frame_info_if          info ();
    tlk_rx_pkg::rx_state_t rx_state;
    logic                  in_frame;
    logic                  link_loss;
    logic                  sync_loss;

    // state exported for status reads
    assign o_rx_state  = rx_state;
    assign o_link_loss = link_loss;
    assign o_sync_loss = sync_loss;

    tlk_frame_parser u_parser (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst_n       (i_rst_n),
        .i_2711_rkmsb  (i_2711_rkmsb),
        .i_2711_rklsb  (i_2711_rklsb),
        .i_2711_rxd    (i_2711_rxd),
        .o_in_frame    (in_frame),
        .o_state       (rx_state),
        .info          (info.src)
    );

    tlk_loss_monitor #(
        .LOSS_HOLDOFF (LOSS_HOLDOFF)
    ) u_loss_monitor (
        .i_2711_rx_clk       (i_2711_rx_clk),
        .i_rst_n             (i_rst_n),
        .i_2711_rkmsb        (i_2711_rkmsb),
        .i_2711_rklsb        (i_2711_rklsb),
        .i_2711_rxd          (i_2711_rxd),
        .i_in_frame          (in_frame),
        .i_link_loss_det_ena (i_link_loss_det_ena),
        .i_sync_loss_det_ena (i_sync_loss_det_ena),
        .o_link_loss         (link_loss),
        .o_sync_loss         (sync_loss)
    );

    tlk_rx_report u_report (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_rst_n        (i_rst_n),
        .i_link_loss    (link_loss),
        .i_sync_loss    (sync_loss),
        .info           (info.dst),
        .o_frame_valid  (o_frame_valid),
        .o_frame_length (o_frame_length),
        .o_frame_num    (o_frame_num),
        .o_data_type    (o_data_type),
        .o_channel_id   (o_channel_id),
        .o_file_end     (o_file_end),
        .o_checksum_err (o_checksum_err),
        .o_frame_count  (o_frame_count),
        .o_loss_irq     (o_loss_irq)
    );

endmodule

// File: testbench/tlk_rx_sva.sv
// concurrent checks on the tlk2711 receive top outputs, bound into the top level
`timescale 1ns/1ps

module tlk_rx_sva #(
    parameter int LOSS_HOLDOFF = 10_000_000
) (
    input logic i_2711_rx_clk,
    input logic i_rst_n,
    input logic o_frame_valid,
    input logic o_loss_irq,
    input logic o_link_loss,
    input logic o_sync_loss
);

    // cycles since the last link loss pulse, saturates at the holdoff
    int   since_link;
    logic seen_link;

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            since_link <= 0;
            seen_link  <= 1'b0;
        end else if (o_link_loss) begin
            since_link <= 0;
            seen_link  <= 1'b1;
        end else if (since_link < LOSS_HOLDOFF) begin
            since_link <= since_link + 1;
        end
    end

    ////////////////////////////////////////
    // output properties
    ////////////////////////////////////////

    // report strobe is one cycle wide
    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_frame_valid |=> !o_frame_valid)
        else $error("o_frame_valid high two cycles in a row");

    // irq trails either loss pulse by one cycle
    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        (o_link_loss || o_sync_loss) |=> o_loss_irq)
        else $error("o_loss_irq missing after a loss pulse");

    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_loss_irq |-> $past(o_link_loss || o_sync_loss))
        else $error("o_loss_irq without a loss pulse");

    // no second link event inside the holdoff window
    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        (o_link_loss && seen_link) |-> (since_link >= LOSS_HOLDOFF))
        else $error("o_link_loss pulsed twice within the holdoff");

endmodule

bind tlk2711_rx_top tlk_rx_sva #(
    .LOSS_HOLDOFF (LOSS_HOLDOFF)
) u_sva (
    .i_2711_rx_clk (i_2711_rx_clk),
    .i_rst_n       (i_rst_n),
    .o_frame_valid (o_frame_valid),
    .o_loss_irq    (o_loss_irq),
    .o_link_loss   (o_link_loss),
    .o_sync_loss   (o_sync_loss)
);

// File: testbench/tb_tlk2711_rx.sv
// testbench for the tlk2711 receive top driving frames and loss faults from a cases file
`timescale 1ns/1ps

module tb_tlk2711_rx;

    localparam int HOLDOFF   = 64;
    localparam int MAX_CASES = 32;

    logic        i_2711_rx_clk = 1'b0;
    logic        i_rst_n;
    logic        i_2711_rkmsb;
    logic        i_2711_rklsb;
    logic [15:0] i_2711_rxd;
    logic        i_link_loss_det_ena;
    logic        i_sync_loss_det_ena;
    logic        o_frame_valid;
    logic [15:0] o_frame_length;
    logic [23:0] o_frame_num;
    logic [3:0]  o_data_type;
    logic [1:0]  o_channel_id;
    logic        o_file_end;
    logic        o_checksum_err;
    logic [15:0] o_frame_count;
    logic        o_loss_irq;
    logic        o_link_loss;
    logic        o_sync_loss;
    logic [3:0]  o_rx_state;

    // six words per test line
    logic [15:0] case_mem [0:6*MAX_CASES-1];
    int          n_cases;
    integer      seed;
    int          err_count;
    int          check_count;
    int          tests_passed;
    int          tests_failed;
    int          frames_expected;
    int          cycle_cnt;
    int          cycle_limit;
    // pulse counts taken on the falling edge
    int          valid_cnt;
    int          link_cnt;
    int          sync_cnt;
    int          irq_cnt;

    tlk2711_rx_top #(
        .LOSS_HOLDOFF (HOLDOFF)
    ) UUT (
        .i_2711_rx_clk       (i_2711_rx_clk),
        .i_rst_n             (i_rst_n),
        .i_2711_rkmsb        (i_2711_rkmsb),
        .i_2711_rklsb        (i_2711_rklsb),
        .i_2711_rxd          (i_2711_rxd),
        .i_link_loss_det_ena (i_link_loss_det_ena),
        .i_sync_loss_det_ena (i_sync_loss_det_ena),
        .o_frame_valid       (o_frame_valid),
        .o_frame_length      (o_frame_length),
        .o_frame_num         (o_frame_num),
        .o_data_type         (o_data_type),
        .o_channel_id        (o_channel_id),
        .o_file_end          (o_file_end),
        .o_checksum_err      (o_checksum_err),
        .o_frame_count       (o_frame_count),
        .o_loss_irq          (o_loss_irq),
        .o_link_loss         (o_link_loss),
        .o_sync_loss         (o_sync_loss),
        .o_rx_state          (o_rx_state)
    );

    // 8 ns period
    always #4 i_2711_rx_clk = ~i_2711_rx_clk;

    // watchdog on the summed test lengths
    always @(posedge i_2711_rx_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: tests still running after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge i_2711_rx_clk) begin
        if (i_rst_n) begin
            if (o_frame_valid) valid_cnt = valid_cnt + 1;
            if (o_link_loss) link_cnt = link_cnt + 1;
            if (o_sync_loss) sync_cnt = sync_cnt + 1;
            if (o_loss_irq) irq_cnt = irq_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            err_count = err_count + 1;
            $display("Error: %s got 0x%0h expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic close_test(input int num, input string label, input int err_before);
        if (err_count == err_before) begin
            tests_passed = tests_passed + 1;
            $display("test %0d %s: pass", num, label);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: FAIL, %0d errors", num, label, err_count - err_before);
        end
    endtask

    // new word 1 ns after the edge
    task automatic send_word(input logic [15:0] w, input logic kmsb, input logic klsb);
        @(posedge i_2711_rx_clk);
        #1;
        i_2711_rxd   = w;
        i_2711_rkmsb = kmsb;
        i_2711_rklsb = klsb;
    endtask

    task automatic send_idle(input int n);
        repeat (n) send_word(16'h0000, 1'b0, 1'b0);
    endtask

    // rough length of one test line for the watchdog
    function automatic int case_cycles(input int kind, input logic [15:0] len, input int fault);
        int n;
        case (kind)
            1, 2: begin
                n = int'(len[15:1]) + 24 + ((kind == 2) ? int'(len[15:1]) + 16 : 0);
                n = n + ((fault != 0) ? HOLDOFF + 8 : 0);
            end
            3, 4:    n = fault + HOLDOFF + 16;
            default: n = 16;
        endcase
        return n;
    endfunction

    ////////////////////////////////////////
    // test kinds
    ////////////////////////////////////////

    // sync, sof, head flag, header, payload, checksum
    task automatic run_frame(input int kind, input logic [15:0] hdr, input logic [15:0] line_lo,
                             input logic [15:0] len, input int corrupt, input int fault);
        tlk_rx_pkg::hdr_word_u hu;
        logic [15:0]           sum;
        logic [15:0]           w;
        integer                rnd;
        int                    v0;
        int                    s0;
        int                    q0;
        int                    i;
        v0     = valid_cnt;
        s0     = sync_cnt;
        q0     = irq_cnt;
        hu.raw = hdr;
        send_idle(2);
        send_word({tlk_rx_pkg::D5_6, tlk_rx_pkg::K28_5}, 1'b0, 1'b1);
        send_word({tlk_rx_pkg::K28_2, tlk_rx_pkg::K27_7}, 1'b1, 1'b1);
        if (kind == 2) begin
            // low half one bit off so the parser keeps hunting
            send_word(tlk_rx_pkg::FRAME_HEAD_FLAG[31:16], 1'b0, 1'b0);
            send_word(tlk_rx_pkg::FRAME_HEAD_FLAG[15:0] ^ 16'h0001, 1'b0, 1'b0);
            // whole frame body behind the bad flag must not be reported
            send_word(hdr, 1'b0, 1'b0);
            send_word(line_lo, 1'b0, 1'b0);
            send_word(len, 1'b0, 1'b0);
            send_idle(int'(len[15:1]));
            send_word(hdr + line_lo + len, 1'b0, 1'b0);
            send_idle(4);
            @(negedge i_2711_rx_clk);
            check_value("o_rx_state", 32'(o_rx_state), 32'(tlk_rx_pkg::frame_head_s));
            check_value("o_frame_valid count", 32'(valid_cnt - v0), 32'd0);
        end
        send_word(tlk_rx_pkg::FRAME_HEAD_FLAG[31:16], 1'b0, 1'b0);
        send_word(tlk_rx_pkg::FRAME_HEAD_FLAG[15:0], 1'b0, 1'b0);
        send_word(hdr, 1'b0, 1'b0);
        send_word(line_lo, 1'b0, 1'b0);
        send_word(len, 1'b0, 1'b0);
        sum = hdr + line_lo + len;
        for (i = 1; i <= int'(len[15:1]); i++) begin
            if (i == fault) begin
                // k chars inside the payload
                w = {tlk_rx_pkg::K28_5, tlk_rx_pkg::K28_5};
                send_word(w, 1'b1, 1'b1);
            end else begin
                rnd = $random(seed);
                w   = rnd[15:0];
                send_word(w, 1'b0, 1'b0);
            end
            sum = sum + w;
        end
        send_word((corrupt != 0) ? ~sum : sum, 1'b0, 1'b0);
        send_idle(4);
        while (valid_cnt == v0) begin
            @(negedge i_2711_rx_clk);
        end
        // clear the sync loss holdoff before the next line
        send_idle((fault != 0) ? HOLDOFF + 8 : 2);
        frames_expected = frames_expected + 1;
        check_value("o_frame_valid count", 32'(valid_cnt - v0), 32'd1);
        check_value("o_checksum_err", 32'(o_checksum_err), (corrupt != 0) ? 32'd1 : 32'd0);
        check_value("o_data_type", 32'(o_data_type), 32'(hu.f.data_type));
        check_value("o_channel_id", 32'(o_channel_id), 32'(hu.f.channel_id));
        check_value("o_file_end", 32'(o_file_end), 32'(hu.f.file_end[0]));
        check_value("o_frame_num", 32'(o_frame_num), 32'({hu.f.line_hi, line_lo}));
        check_value("o_frame_length", 32'(o_frame_length), 32'(len));
        check_value("o_frame_count", 32'(o_frame_count), 32'(frames_expected));
        check_value("o_sync_loss count", 32'(sync_cnt - s0), (fault != 0) ? 32'd1 : 32'd0);
        check_value("o_loss_irq count", 32'(irq_cnt - q0), (fault != 0) ? 32'd1 : 32'd0);
    endtask

    // two link loss words gap edges apart
    task automatic run_link(input logic ena, input int gap);
        int l0;
        int q0;
        int expected;
        @(posedge i_2711_rx_clk);
        #1;
        i_link_loss_det_ena = ena;
        send_idle(2);
        l0 = link_cnt;
        q0 = irq_cnt;
        send_word(tlk_rx_pkg::LINK_LOSS_WORD, 1'b1, 1'b1);
        send_idle(gap - 1);
        send_word(tlk_rx_pkg::LINK_LOSS_WORD, 1'b1, 1'b1);
        send_idle(HOLDOFF + 8);
        if (!ena) begin
            expected = 0;
        end else if (gap > HOLDOFF) begin
            expected = 2;
        end else begin
            expected = 1;
        end
        check_value("o_link_loss count", 32'(link_cnt - l0), 32'(expected));
        check_value("o_loss_irq count", 32'(irq_cnt - q0), 32'(expected));
        @(posedge i_2711_rx_clk);
        #1;
        i_link_loss_det_ena = 1'b1;
    endtask

    // k word while idle must not raise sync loss
    task automatic run_kword();
        int s0;
        s0 = sync_cnt;
        send_idle(2);
        repeat (3) send_word({tlk_rx_pkg::K28_5, tlk_rx_pkg::K28_5}, 1'b1, 1'b1);
        send_idle(4);
        @(negedge i_2711_rx_clk);
        check_value("o_sync_loss count", 32'(sync_cnt - s0), 32'd0);
        check_value("o_rx_state", 32'(o_rx_state), 32'(tlk_rx_pkg::idle_s));
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int          k;
        int          err_before;
        int          kind;
        int          corrupt;
        int          fault;
        logic [15:0] hdr;
        logic [15:0] line_lo;
        logic [15:0] len;
        string       label;
        i_rst_n             = 1'b0;
        i_2711_rkmsb        = 1'b0;
        i_2711_rklsb        = 1'b0;
        i_2711_rxd          = 16'h0000;
        i_link_loss_det_ena = 1'b1;
        i_sync_loss_det_ena = 1'b1;
        seed            = 32'hd4af;
        err_count       = 0;
        check_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        frames_expected = 0;
        valid_cnt       = 0;
        link_cnt        = 0;
        sync_cnt        = 0;
        irq_cnt         = 0;
        cycle_cnt       = 0;
        // reset plus margin before the test lines are added
        cycle_limit     = 208;
        $readmemh("testbench/rx_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && !$isunknown(case_mem[6*n_cases]) &&
               case_mem[6*n_cases] != 16'h0000) begin
            cycle_limit = cycle_limit + case_cycles(int'(case_mem[6*n_cases]),
                                                    case_mem[6*n_cases+3],
                                                    int'(case_mem[6*n_cases+5]));
            n_cases = n_cases + 1;
        end

        repeat (8) @(posedge i_2711_rx_clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge i_2711_rx_clk);
        err_before = err_count;
        check_value("o_frame_valid", 32'(o_frame_valid), 32'd0);
        check_value("o_link_loss", 32'(o_link_loss), 32'd0);
        check_value("o_sync_loss", 32'(o_sync_loss), 32'd0);
        check_value("o_loss_irq", 32'(o_loss_irq), 32'd0);
        check_value("o_frame_count", 32'(o_frame_count), 32'd0);
        check_value("o_rx_state", 32'(o_rx_state), 32'(tlk_rx_pkg::idle_s));
        close_test(0, "reset", err_before);
        if (n_cases == 0) begin
            $display("no test lines could be read from testbench/rx_cases.txt");
            err_count = err_count + 1;
        end

        for (k = 0; k < n_cases; k++) begin
            kind       = int'(case_mem[6*k]);
            hdr        = case_mem[6*k+1];
            line_lo    = case_mem[6*k+2];
            len        = case_mem[6*k+3];
            corrupt    = int'(case_mem[6*k+4]);
            fault      = int'(case_mem[6*k+5]);
            err_before = err_count;
            case (kind)
                1, 2: begin
                    label = (kind == 2) ? "bad head then frame" : "frame";
                    if (corrupt != 0) label = {label, ", bad checksum"};
                    if (fault != 0) label = {label, ", sync loss"};
                    run_frame(kind, hdr, line_lo, len, corrupt, fault);
                end
                3, 4: begin
                    label = (kind == 3) ? "link loss enabled" : "link loss disabled";
                    run_link(kind == 3, fault);
                end
                5: begin
                    label = "k word between frames";
                    run_kword();
                end
                default: begin
                    label = "unknown kind";
                    $display("test %0d has an unknown kind %0d", k + 1, kind);
                    err_count = err_count + 1;
                end
            endcase
            close_test(k + 1, label, err_before);
        end

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: testbench/rx_cases.txt
// columns: kind header line_lo length_bytes corrupt fault (all hex)
// kind 1 frame, 2 bad head then frame, 3 link loss on, 4 link loss off, 5 k word idle
// fault: frame = payload word (from 1) with k chars; link loss = edges to repeat
1 4a35 0001 0010 0 0
1 8c12 0002 0020 1 0
1 c7ff 0003 0008 0 0
2 1b80 0104 000c 0 0
1 5e01 0005 0006 0 3
5 0000 0000 0000 0 0
3 0000 0000 0000 0 0014
3 0000 0000 0000 0 0064
4 0000 0000 0000 0 0014
1 ffff ffff 0002 0 0
1 0000 0000 0040 1 0
1 3333 1234 0012 0 9
1 6a5c 00ff 0004 0 0
0 0000 0000 0000 0 0

// File: verilog.f
source/tlk_rx_pkg.sv
source/frame_info_if.sv
source/tlk_frame_parser.sv
source/tlk_loss_monitor.sv
source/tlk_rx_report.sv
source/tlk2711_rx_top.sv
testbench/tlk_rx_sva.sv
testbench/tb_tlk2711_rx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tlk2711 receive testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_tlk2711_rx -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }
